//--- src/fetch_pkg.sv
// shared fetch types; addresses are byte addresses and a fetch block is always 8-byte aligned
package fetch_pkg;

	//////////////////////////////////////////////////
	// widths that carry a meaning
	//////////////////////////////////////////////////

	// byte address, low three bits zero for a fetch block
	typedef logic [63:0] addr_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// two instructions, lower half = lower address
	typedef logic [63:0] block_t;

	// hardware thread number
	typedef logic thread_t;	// 0 is the first thread

	//////////////////////////////////////////////////
	// thread select FSM
	//////////////////////////////////////////////////

	// remembers who fetched last so the other one goes next
	typedef enum logic [1:0]
	{
		SEL_START   = 2'd0,	// after reset, nothing issued yet
		SEL_LAST_T0 = 2'd1,	// thread 0 issued last
		SEL_LAST_T1 = 2'd2	// thread 1 issued last
	} sel_state_e;

endpackage

//--- src/thread_pc.sv
// one thread's fetch PC; RESET_PC and redirect targets are forced to 8-byte alignment
`timescale 1ns/100ps

module thread_pc import fetch_pkg::*;
#(
	parameter addr_t RESET_PC = 64'h0
)
(
	input  logic  clock,
	input  logic  reset,
	input  logic  advance,	// fetch of the current block delivered
	input  logic  redirect,	// taken branch from execute
	input  addr_t target,
	output addr_t pc
);

	addr_t target_aligned;
	addr_t pc_next_seq;

	// drop the byte offset within the block
	assign target_aligned = {target[63:3], 3'b000};
	assign pc_next_seq = pc + 64'd8;	// two instructions per block

	//////////////////////////////////////////////////
	// pc register
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc <= {RESET_PC[63:3], 3'b000};
		end
		else if (redirect)
		begin
			// redirect beats advance in the same cycle
			pc <= target_aligned;
		end
		else if (advance)
		begin
			pc <= pc_next_seq;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_pc_aligned: assert property (@(posedge clock) disable iff (reset)
		pc[2:0] == 3'b000)
		else $error("thread_pc: pc not block aligned");

endmodule

//--- src/fetch_thread_select.sv
// thread choice and fetch tracking; one fetch in flight at a time, stalls only block new requests
`timescale 1ns/100ps

module fetch_thread_select import fetch_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    two_threads,	// low = thread 0 only
	input  logic    stall0,
	input  logic    stall1,
	input  logic    redirect0,
	input  logic    redirect1,
	input  addr_t   pc0,
	input  addr_t   pc1,
	input  logic    fetch_busy,
	input  logic    fetch_done,
	input  block_t  fetch_data,
	output logic    fetch_req,
	output addr_t   fetch_adr,
	output logic    advance0,
	output logic    advance1,
	output logic    out_valid,
	output inst_t   out_inst0,
	output inst_t   out_inst1,
	output addr_t   out_pc,
	output thread_t out_thread
);

	sel_state_e sel_state;
	thread_t    pref;		// thread that did not issue last
	thread_t    pick;
	logic       pick_ok;	// some thread may fetch
	logic       pick_redirect;
	logic       done_q;		// fetch_done seen last cycle

	// fetch in flight
	thread_t    fl_thread;
	addr_t      fl_adr;
	logic       fl_cancel;
	logic       fl_redirect;
	logic       drop;

	//////////////////////////////////////////////////
	// thread choice
	//////////////////////////////////////////////////

	// start behaves like thread 0 went first, so thread 1 leads
	assign pref = (sel_state == SEL_LAST_T1) ? 1'b0 : 1'b1;

	always_comb
	begin
		pick = 1'b0;
		pick_ok = 1'b0;
		if (!two_threads)
		begin
			pick_ok = !stall0;
		end
		else if (pref ? !stall1 : !stall0)
		begin
			pick = pref;
			pick_ok = 1'b1;
		end
		else if (pref ? !stall0 : !stall1)
		begin
			pick = !pref;	// fall back to the other thread
			pick_ok = 1'b1;
		end
	end

	assign fetch_req = pick_ok && !fetch_busy && !done_q;
	assign fetch_adr = pick ? pc1 : pc0;
	assign pick_redirect = pick ? redirect1 : redirect0;

	//////////////////////////////////////////////////
	// completion
	//////////////////////////////////////////////////

	assign fl_redirect = fl_thread ? redirect1 : redirect0;
	assign drop = fl_cancel || fl_redirect;	// branch in the ack cycle counts too

	assign advance0 = fetch_done && !drop && (fl_thread == 1'b0);
	assign advance1 = fetch_done && !drop && (fl_thread == 1'b1);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			sel_state <= SEL_START;
			fl_cancel <= 1'b0;
			done_q <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			done_q <= fetch_done;
			out_valid <= fetch_done && !drop;
			if (fetch_req)
			begin
				sel_state <= pick ? SEL_LAST_T1 : SEL_LAST_T0;
				fl_cancel <= pick_redirect;	// pc already stale
			end
			else if (fl_redirect)
			begin
				fl_cancel <= 1'b1;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clock)
	begin
		if (fetch_req)
		begin
			fl_thread <= pick;
			fl_adr <= fetch_adr;
		end
		if (fetch_done && !drop)
		begin
			out_inst0 <= fetch_data[31:0];
			out_inst1 <= fetch_data[63:32];
			out_pc <= fl_adr;
			out_thread <= fl_thread;
		end
	end

	a_one_advance: assert property (@(posedge clock) disable iff (reset)
		!(advance0 && advance1))
		else $error("fetch_thread_select: both threads advanced");

endmodule

//--- src/imem_wb_master.sv
// Wishbone classic read master, single 64-bit transfer per cycle; no err, rty or bursts
`timescale 1ns/100ps

module imem_wb_master import fetch_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   fetch_req,
	input  addr_t  fetch_adr,
	output logic   fetch_busy,
	output logic   fetch_done,
	output block_t fetch_data,
	output logic   wb_cyc,
	output logic   wb_stb,
	output logic   wb_we,
	output addr_t  wb_adr,
	input  block_t wb_dat_i,
	input  logic   wb_ack
);

	typedef enum logic {WB_IDLE, WB_BUS} wb_state_e;

	wb_state_e state;
	addr_t     adr_q;	// held for the whole cycle

	//////////////////////////////////////////////////
	// bus FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= WB_IDLE;
		else if (state == WB_IDLE && fetch_req)
			state <= WB_BUS;
		else if (state == WB_BUS && wb_ack)
			state <= WB_IDLE;	// cyc/stb drop after the ack edge
	end

	always_ff @(posedge clock)
	begin
		if (state == WB_IDLE && fetch_req)
			adr_q <= fetch_adr;
	end

	assign wb_cyc = (state == WB_BUS);
	assign wb_stb = (state == WB_BUS);
	assign wb_we = 1'b0;	// read only
	assign wb_adr = adr_q;

	assign fetch_busy = (state == WB_BUS);
	assign fetch_done = (state == WB_BUS) && wb_ack;
	assign fetch_data = wb_dat_i;

	a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
		wb_stb |-> wb_cyc)
		else $error("imem_wb_master: stb without cyc");

endmodule

//--- src/fetch_top.sv
// fetch stage top; the core combines ROB, RS and rename stalls into stall0/stall1 before this point
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*;
#(
	parameter addr_t RESET_PC0 = 64'h0000_0000_0000_0000,
	parameter addr_t RESET_PC1 = 64'h0000_0000_0000_1000
)
(
	input  logic    clock,
	input  logic    reset,
	input  logic    two_threads,
	input  logic    stall0,
	input  logic    stall1,
	input  logic    branch_taken0,
	input  logic    branch_taken1,
	input  addr_t   branch_target0,
	input  addr_t   branch_target1,
	// instruction memory, Wishbone classic
	output logic    wb_cyc,
	output logic    wb_stb,
	output logic    wb_we,
	output addr_t   wb_adr,
	input  block_t  wb_dat_i,
	input  logic    wb_ack,
	// towards decode
	output logic    out_valid,
	output inst_t   out_inst0,
	output inst_t   out_inst1,
	output addr_t   out_pc,
	output thread_t out_thread
);

	addr_t  pc0;
	addr_t  pc1;
	logic   advance0;
	logic   advance1;
	logic   fetch_req;
	addr_t  fetch_adr;
	logic   fetch_busy;
	logic   fetch_done;
	block_t fetch_data;

	//////////////////////////////////////////////////
	// per-thread PCs
	//////////////////////////////////////////////////

	thread_pc #(.RESET_PC(RESET_PC0)) pc0_i
	(
		.clock(clock), .reset(reset),
		.advance(advance0), .redirect(branch_taken0), .target(branch_target0),
		.pc(pc0)
	);

	thread_pc #(.RESET_PC(RESET_PC1)) pc1_i
	(
		.clock(clock), .reset(reset),
		.advance(advance1), .redirect(branch_taken1), .target(branch_target1),
		.pc(pc1)
	);

	//////////////////////////////////////////////////
	// selector and bus master
	//////////////////////////////////////////////////

	fetch_thread_select select_i
	(
		.clock(clock), .reset(reset), .two_threads(two_threads),
		.stall0(stall0), .stall1(stall1),
		.redirect0(branch_taken0), .redirect1(branch_taken1),
		.pc0(pc0), .pc1(pc1),
		.fetch_busy(fetch_busy), .fetch_done(fetch_done), .fetch_data(fetch_data),
		.fetch_req(fetch_req), .fetch_adr(fetch_adr),
		.advance0(advance0), .advance1(advance1),
		.out_valid(out_valid), .out_inst0(out_inst0), .out_inst1(out_inst1),
		.out_pc(out_pc), .out_thread(out_thread)
	);

	imem_wb_master wb_master_i
	(
		.clock(clock), .reset(reset),
		.fetch_req(fetch_req), .fetch_adr(fetch_adr),
		.fetch_busy(fetch_busy), .fetch_done(fetch_done), .fetch_data(fetch_data),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
	);

endmodule

//--- tb/imem_model.sv
// instruction memory model; each returned word equals its byte address (low 32 bits), 0 to 3 wait states
`timescale 1ns/100ps

module imem_model import fetch_pkg::*;
(
	input  logic   clock,
	input  logic   reset,
	input  logic   wb_cyc,
	input  logic   wb_stb,
	input  logic   wb_we,
	input  addr_t  wb_adr,
	output block_t wb_dat,
	output logic   wb_ack
);

	integer      seed = 77718;
	logic [31:0] draw;
	logic [1:0]  wait_left;	// wait states left for the current or next cycle

	//////////////////////////////////////////////////
	// data and ack
	//////////////////////////////////////////////////

	// lower half is the word at the block address
	assign wb_dat = {wb_adr[31:0] + 32'd4, wb_adr[31:0]};

	// zero wait states acks in the first cycle of the request
	assign wb_ack = wb_cyc && wb_stb && !wb_we && (wait_left == 2'd0);

	always @(posedge clock)
	begin
		if (reset || wb_ack)
		begin
			draw = $random(seed);	// wait count for the next transfer
			wait_left <= draw[1:0];
		end
		else if (wb_cyc && wb_stb)
		begin
			wait_left <= wait_left - 2'd1;
		end
	end

endmodule

//--- tb/fetch_tb.sv
// fetch stage testbench; expected PCs are kept here per thread, checks are concurrent assertions
`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*;
();

	localparam addr_t RESET_PC0 = 64'h0000_0000_0000_0100;
	localparam addr_t RESET_PC1 = 64'h0000_0000_0000_8000;
	localparam int RESET_CYCLES = 4;
	localparam int BOTH_STALL_CYCLES = 20;
	localparam int BRANCH_COUNT = 6;
	localparam int EXPECTED_OUTPUTS = 8 + 12 + 10 + 1 + 3 * BRANCH_COUNT + 2;
	localparam int WATCHDOG_CYCLES = 40 * EXPECTED_OUTPUTS + BOTH_STALL_CYCLES + RESET_CYCLES
		+ 5 * BRANCH_COUNT;

	logic clock, reset, two_threads, stall0, stall1, branch_taken0, branch_taken1;
	addr_t branch_target0, branch_target1, wb_adr, out_pc, exp_pc0, exp_pc1, exp_out;
	logic wb_cyc, wb_stb, wb_we, wb_ack, out_valid;
	block_t wb_dat;
	inst_t out_inst0, out_inst1;
	thread_t out_thread, last_thread;
	logic single_on, alt_on, stall_on;	// which checks are armed
	int out_count;
	int thread_count [2];
	integer seed = 77718;

	fetch_top #(.RESET_PC0(RESET_PC0), .RESET_PC1(RESET_PC1)) dut_i
	(
		.clock(clock), .reset(reset), .two_threads(two_threads),
		.stall0(stall0), .stall1(stall1),
		.branch_taken0(branch_taken0), .branch_taken1(branch_taken1),
		.branch_target0(branch_target0), .branch_target1(branch_target1),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat), .wb_ack(wb_ack),
		.out_valid(out_valid), .out_inst0(out_inst0), .out_inst1(out_inst1),
		.out_pc(out_pc), .out_thread(out_thread)
	);

	imem_model mem_i
	(
		.clock(clock), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat(wb_dat), .wb_ack(wb_ack)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// expected PCs and output counters
	//////////////////////////////////////////////////

	assign exp_out = out_thread ? exp_pc1 : exp_pc0;

	always @(posedge clock)
	begin
		if (reset)
		begin
			exp_pc0 <= RESET_PC0;
			exp_pc1 <= RESET_PC1;
			out_count <= 0;
			thread_count[0] <= 0;
			thread_count[1] <= 0;
			last_thread <= 1'b0;
		end
		else
		begin
			if (out_valid)
			begin
				out_count <= out_count + 1;
				thread_count[out_thread] <= thread_count[out_thread] + 1;
				last_thread <= out_thread;
			end
			// a branch wins over the output seen in the same cycle
			if (branch_taken0)
				exp_pc0 <= {branch_target0[63:3], 3'b000};
			else if (out_valid && !out_thread)
				exp_pc0 <= exp_pc0 + 64'd8;
			if (branch_taken1)
				exp_pc1 <= {branch_target1[63:3], 3'b000};
			else if (out_valid && out_thread)
				exp_pc1 <= exp_pc1 + 64'd8;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("mismatch %s: got %h expected %h", name, got, want);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	a_reset_quiet: assert property (@(posedge clock) reset |=> !wb_cyc && !wb_stb && !out_valid)
		else report_failure("bus or output active during or right after reset");
	a_read_only: assert property (@(posedge clock) disable iff (reset) wb_cyc |-> !wb_we)
		else report_failure("write strobe seen on the instruction bus");
	a_inst0: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_inst0 == out_pc[31:0])
		else report_mismatch("out_inst0", 64'($sampled(out_inst0)), $sampled(out_pc));
	a_inst1: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> out_inst1 == out_pc[31:0] + 32'd4)
		else report_mismatch("out_inst1", 64'($sampled(out_inst1)), $sampled(out_pc) + 64'd4);
	a_pc: assert property (@(posedge clock) disable iff (reset) out_valid |-> out_pc == exp_out)
		else report_mismatch("out_pc", $sampled(out_pc), $sampled(exp_out));
	a_single: assert property (@(posedge clock) disable iff (reset)
		out_valid && (single_on || stall_on) |-> out_thread == 1'b0)
		else report_mismatch("out_thread", 64'($sampled(out_thread)), 64'h0);
	a_alternate: assert property (@(posedge clock) disable iff (reset)
		out_valid && alt_on |-> out_thread != last_thread)
		else report_mismatch("out_thread", 64'($sampled(out_thread)), 64'(!$sampled(last_thread)));
	a_no_start: assert property (@(posedge clock) disable iff (reset)
		stall0 && stall1 |=> !$rose(wb_cyc))
		else report_failure("bus cycle started with both threads stalled");

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	task automatic wait_outputs(input int n);
		int target;
		target = out_count + n;
		while (out_count < target)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic wait_thread_output(input thread_t t);
		int target;
		target = thread_count[t] + 1;
		while (thread_count[t] < target)
		begin
			@(posedge clock);
			#1;
		end
	endtask

	// one-cycle branch pulse, then wait for the redirected thread's next output
	task automatic branch_and_check(input thread_t t, input addr_t target);
		@(posedge clock);
		#1;
		branch_taken0 = !t;
		branch_taken1 = t;
		branch_target0 = target;
		branch_target1 = target;
		@(posedge clock);
		#1;
		branch_taken0 = 1'b0;
		branch_taken1 = 1'b0;
		wait_thread_output(t);
	endtask

	initial
	begin
		logic [31:0] draw;
		addr_t target;
		reset = 1'b1;
		two_threads = 1'b0;
		stall0 = 1'b0;
		stall1 = 1'b0;
		branch_taken0 = 1'b0;
		branch_taken1 = 1'b0;
		branch_target0 = '0;
		branch_target1 = '0;
		single_on = 1'b1;
		alt_on = 1'b0;
		stall_on = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		wait_outputs(8);	// thread 0 only
		single_on = 1'b0;
		two_threads = 1'b1;
		wait_outputs(1);
		alt_on = 1'b1;
		wait_outputs(11);
		alt_on = 1'b0;
		stall1 = 1'b1;
		wait_outputs(2);	// let a thread 1 fetch in flight drain
		stall_on = 1'b1;
		wait_outputs(8);
		stall_on = 1'b0;
		stall1 = 1'b0;
		wait_thread_output(1'b1);
		stall0 = 1'b1;
		stall1 = 1'b1;
		repeat (BOTH_STALL_CYCLES) @(posedge clock);
		#1;
		stall0 = 1'b0;
		stall1 = 1'b0;
		for (int i = 0; i < BRANCH_COUNT; i++)
		begin
			draw = $random(seed);
			repeat (draw[13:12]) @(posedge clock);	// vary the hit point in the fetch
			target = (i % 2 == 1) ? 64'h0002_0000 : 64'h0001_0000;
			target = target + {52'h0, draw[11:0]};	// low bits may be unaligned
			branch_and_check(thread_t'(i % 2), target);
		end
		wait_outputs(2);
		$display("Test completed successfully");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		report_failure("watchdog expired before all outputs arrived");
	end

endmodule

//--- sim.f
src/fetch_pkg.sv
src/thread_pc.sv
src/fetch_thread_select.sv
src/imem_wb_master.sv
src/fetch_top.sv
tb/imem_model.sv
tb/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it; exit status carries pass or fail
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f sim.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim \
	&& ./obj_dir/fetch_sim \
	|| exit 1
